// ==== verilog.f ====
common/core_stream_pkg.sv
common/cont_read_pkg.sv
hw/desc_fifo.sv
slot_tracker/slot_tracker.sv
readout/scratchpad_ram.sv
readout/readout_engine.sv
hw/pcie_cont_read.sv
test/tb_pcie_cont_read.sv

// ==== test/tb_pcie_cont_read.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_pcie_cont_read
  import cont_read_pkg::*, core_stream_pkg::*;
();

  localparam int clk_period = 8;
  localparam int max_wait   = 200;
  // Rough cycle budget of host, core, priority, exhaustion, back-pressure and enable tests
  localparam int test_cycles     = 40 + 40 + 80 + 600 + 150 + 60;
  localparam int watchdog_cycles = test_cycles * 4;

  logic                  pcie_clk;
  logic                  pcie_rst;
  logic                  dma_enable;
  host_req_t             host_req;
  logic                  host_req_valid;
  logic                  host_req_ready;
  logic [host_tag_w-1:0] host_status_tag;
  logic                  host_status_valid;
  core_req_t             core_req;
  logic [core_id_w-1:0]  core_id;
  logic                  core_req_valid;
  logic                  core_req_ready;
  pcie_desc_t            pcie_desc;
  slot_t                 pcie_desc_tag;
  logic                  pcie_desc_valid;
  logic                  pcie_desc_ready;
  slot_t                 dma_status_tag;
  logic                  dma_status_valid;
  ram_wr_t               dma_wr;
  logic                  dma_wr_valid;
  core_beat_t            core_beat;
  logic                  core_valid;
  logic                  core_ready;

  int                    error_count = 0;
  logic [31:0]           rng_state   = 32'h26c3;

  pcie_cont_read i_dut (
    .pcie_clk          (pcie_clk),
    .pcie_rst          (pcie_rst),
    .dma_enable        (dma_enable),
    .host_req          (host_req),
    .host_req_valid    (host_req_valid),
    .host_req_ready    (host_req_ready),
    .host_status_tag   (host_status_tag),
    .host_status_valid (host_status_valid),
    .core_req          (core_req),
    .core_id           (core_id),
    .core_req_valid    (core_req_valid),
    .core_req_ready    (core_req_ready),
    .pcie_desc         (pcie_desc),
    .pcie_desc_tag     (pcie_desc_tag),
    .pcie_desc_valid   (pcie_desc_valid),
    .pcie_desc_ready   (pcie_desc_ready),
    .dma_status_tag    (dma_status_tag),
    .dma_status_valid  (dma_status_valid),
    .dma_wr            (dma_wr),
    .dma_wr_valid      (dma_wr_valid),
    .core_beat         (core_beat),
    .core_valid        (core_valid),
    .core_ready        (core_ready)
  );

  initial begin
    pcie_clk = 1'b0;
    forever #(clk_period / 2) pcie_clk = ~pcie_clk;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge pcie_clk);
    stop_on_error("Simulation ran past its cycle limit, a handshake never completed");
  end

  task automatic stop_on_error(input string reason);
    error_count++;
    $display("%s", reason);
    $display("** FAIL **");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string test_name, input string what,
                             input logic [159:0] expected, input logic [159:0] actual);
    if (expected !== actual) begin
      stop_on_error($sformatf("FAILED %s: %s expected %0h actual %0h",
                              test_name, what, expected, actual));
    end
  endtask

  task automatic tick_wait(inout int waited, input string what);
    waited++;
    if (waited > max_wait) begin
      stop_on_error({"Timed out waiting for ", what});
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Word k of slot s in the scratchpad
  function automatic logic [127:0] pattern(input int s, input int k);
    logic [31:0] w;
    w = {8'h5a, 4'(s), 9'h0, 11'(k)};
    return {w, ~w, w ^ 32'h3c3c_3c3c, {w[15:0], w[31:16]}};
  endfunction

  function automatic logic [15:0] tail_keep(input int len);
    int rem;
    rem = len % 16;
    if (rem == 0) begin
      return 16'hffff;
    end
    return 16'((1 << rem) - 1);
  endfunction

  function automatic host_req_t make_host(input logic [63:0] addr, input logic [3:0] cid,
                                          input logic [15:0] caddr, input int len,
                                          input logic [31:0] tag);
    host_req_t r;
    r.pcie_addr = addr;
    r.ram_addr  = {cid, caddr};
    r.len       = len_w'(len);
    r.tag       = tag;
    return r;
  endfunction

  function automatic core_req_t make_core(input logic [63:0] addr, input logic [15:0] caddr,
                                          input logic [4:0] dest_low, input int len);
    core_req_t r;
    r.pcie_addr = addr;
    r.core_addr = caddr;
    r.dest_low  = dest_low;
    r.len       = len_w'(len);
    return r;
  endfunction

  task automatic send_host(input host_req_t r);
    int waited;
    waited = 0;
    @(negedge pcie_clk);
    host_req       = r;
    host_req_valid = 1'b1;
    #1;
    while (!host_req_ready) begin
      @(negedge pcie_clk);
      #1;
      tick_wait(waited, "host request accept");
    end
    @(negedge pcie_clk);
    host_req_valid = 1'b0;
  endtask

  // Entered just after a falling edge with core_req_valid high
  task automatic wait_core_accept();
    int waited;
    waited = 0;
    #1;
    while (!core_req_ready) begin
      @(negedge pcie_clk);
      #1;
      tick_wait(waited, "core request accept");
    end
    @(negedge pcie_clk);
    core_req_valid = 1'b0;
  endtask

  task automatic send_core(input core_req_t r, input logic [3:0] id);
    @(negedge pcie_clk);
    core_req       = r;
    core_id        = id;
    core_req_valid = 1'b1;
    wait_core_accept();
  endtask

  task automatic expect_desc(input string test_name, input logic [63:0] addr, input int len,
                             input int slot, output pcie_desc_t d);
    int waited;
    waited = 0;
    @(negedge pcie_clk);
    pcie_desc_ready = 1'b1;
    #1;
    while (!pcie_desc_valid) begin
      @(negedge pcie_clk);
      #1;
      tick_wait(waited, "outbound descriptor");
    end
    d = pcie_desc;
    check_value(test_name, "descriptor tag port", slot, pcie_desc_tag);
    @(negedge pcie_clk);
    pcie_desc_ready = 1'b0;
    check_value(test_name, "descriptor pcie_addr", addr, d.pcie_addr);
    check_value(test_name, "descriptor ram_addr", slot * slot_bytes, d.ram_addr);
    check_value(test_name, "descriptor len", len, d.len);
    check_value(test_name, "descriptor tag", slot, d.tag);
  endtask

  // DMA engine model: fill the slot region, then report the slot done
  task automatic complete_slot(input pcie_desc_t d);
    int nwords;
    int k;
    nwords = (int'(d.len) + 15) / 16;
    for (k = 0; k < nwords; k++) begin
      @(negedge pcie_clk);
      dma_wr.addr  = word_addr_w'((d.ram_addr >> word_lsb) + k);
      dma_wr.data  = pattern(d.tag, k);
      dma_wr_valid = 1'b1;
    end
    @(negedge pcie_clk);
    dma_wr_valid     = 1'b0;
    dma_status_tag   = d.tag;
    dma_status_valid = 1'b1;
    @(negedge pcie_clk);
    dma_status_valid = 1'b0;
  endtask

  task automatic recv_packet(input string test_name, input int slot, input int len,
                             input logic [8:0] dest, input logic [15:0] caddr,
                             input bit random_ready);
    int           total;
    int           got;
    int           waited;
    bit           stalled;
    core_beat_t   held;
    logic [127:0] exp_data;
    logic [15:0]  exp_keep;
    logic         exp_last;
    total   = (len + 15) / 16 + 1;
    got     = 0;
    waited  = 0;
    stalled = 1'b0;
    while (got < total) begin
      @(negedge pcie_clk);
      if (stalled) begin
        check_value(test_name, "core_valid under back-pressure", 1, core_valid);
        check_value(test_name, "beat held under back-pressure", held, core_beat);
      end
      rng_state  = xorshift32(rng_state);
      core_ready = random_ready ? rng_state[3] : 1'b1;
      if (core_valid) begin
        waited  = 0;
        stalled = !core_ready;
        held    = core_beat;
        if (core_ready) begin
          if (got == 0) begin
            exp_data = 128'(caddr) << hdr_addr_lsb;
            exp_keep = 16'h00ff;
            exp_last = 1'b0;
          end else begin
            exp_data = pattern(slot, got - 1);
            exp_last = (got == total - 1);
            exp_keep = exp_last ? tail_keep(len) : 16'hffff;
          end
          check_value(test_name, $sformatf("beat %0d data", got), exp_data, core_beat.data);
          check_value(test_name, $sformatf("beat %0d keep", got), exp_keep, core_beat.keep);
          check_value(test_name, $sformatf("beat %0d dest", got), dest, core_beat.dest);
          check_value(test_name, $sformatf("beat %0d last", got), exp_last, core_beat.last);
          got++;
        end
      end else begin
        stalled = 1'b0;
        tick_wait(waited, "output beat");
      end
    end
    @(negedge pcie_clk);
    core_ready = 1'b0;
  endtask

  task automatic wait_status(input string test_name, input logic [31:0] tag);
    int waited;
    waited = 0;
    @(negedge pcie_clk);
    while (!host_status_valid) begin
      @(negedge pcie_clk);
      tick_wait(waited, "host status");
    end
    check_value(test_name, "host_status_tag", tag, host_status_tag);
  endtask

  task automatic expect_no_status(input int cycles);
    repeat (cycles) begin
      @(negedge pcie_clk);
      if (host_status_valid) begin
        stop_on_error("A host status appeared for a core request");
      end
    end
  endtask

  task automatic test_host_read();
    host_req_t  r;
    pcie_desc_t d;
    r = make_host(64'h0000_0040_1234_5000, 4'h3, 16'h0a10, 100, 32'hbeef_0001);
    send_host(r);
    expect_desc("host_read", r.pcie_addr, 100, 0, d);
    complete_slot(d);
    recv_packet("host_read", 0, 100, {4'h3, 5'd0}, 16'h0a10, 1'b0);
    wait_status("host_read", 32'hbeef_0001);
  endtask

  task automatic test_core_read();
    core_req_t  r;
    pcie_desc_t d;
    r = make_core(64'h0000_0002_0000_1000, 16'h0200, 5'd17, 48);
    send_core(r, 4'h9);
    expect_desc("core_read", r.pcie_addr, 48, 0, d);
    complete_slot(d);
    recv_packet("core_read", 0, 48, {4'h9, 5'd17}, 16'h0200, 1'b0);
    expect_no_status(10);
  endtask

  task automatic test_priority();
    host_req_t  hr;
    core_req_t  cr;
    pcie_desc_t d0;
    pcie_desc_t d1;
    hr = make_host(64'h0000_0000_aaaa_0000, 4'h5, 16'h0040, 32, 32'h0000_0777);
    cr = make_core(64'h0000_0000_bbbb_0000, 16'h0080, 5'd9, 20);
    @(negedge pcie_clk);
    host_req       = hr;
    host_req_valid = 1'b1;
    core_req       = cr;
    core_id        = 4'h2;
    core_req_valid = 1'b1;
    #1;
    check_value("priority", "host_req_ready", 1, host_req_ready);
    check_value("priority", "core_req_ready", 0, core_req_ready);
    @(negedge pcie_clk);
    host_req_valid = 1'b0;
    wait_core_accept();
    expect_desc("priority", hr.pcie_addr, 32, 0, d0);
    expect_desc("priority", cr.pcie_addr, 20, 1, d1);
    complete_slot(d0);
    recv_packet("priority", 0, 32, {4'h5, 5'd0}, 16'h0040, 1'b0);
    wait_status("priority", 32'h0000_0777);
    complete_slot(d1);
    recv_packet("priority", 1, 20, {4'h2, 5'd9}, 16'h0080, 1'b0);
    expect_no_status(10);
  endtask

  task automatic test_exhaustion();
    core_req_t  r;
    pcie_desc_t d [slot_count];
    int         i;
    r = '0;
    for (i = 0; i < slot_count; i++) begin
      r = make_core(64'h1000_0000 + 64'(i) * 64'h100, 16'(i * 16), 5'(i), 16);
      send_core(r, 4'h1);
      expect_desc("exhaustion", r.pcie_addr, 16, i, d[i]);
    end
    @(negedge pcie_clk);
    check_value("exhaustion", "host_req_ready when full", 0, host_req_ready);
    check_value("exhaustion", "core_req_ready when full", 0, core_req_ready);
    complete_slot(d[5]);
    recv_packet("exhaustion", 5, 16, {4'h1, 5'd5}, 16'h0050, 1'b0);
    r = make_core(64'h2000_0000, 16'h7777, 5'd20, 16);
    send_core(r, 4'h1);
    expect_desc("exhaustion", r.pcie_addr, 16, 5, d[5]);
    // Drain every slot so later tests start from an empty tracker
    for (i = 0; i < slot_count; i++) begin
      complete_slot(d[i]);
      if (i == 5) begin
        recv_packet("exhaustion", 5, 16, {4'h1, 5'd20}, 16'h7777, 1'b0);
      end else begin
        recv_packet("exhaustion", i, 16, {4'h1, 5'(i)}, 16'(i * 16), 1'b0);
      end
    end
  endtask

  task automatic test_backpressure();
    core_req_t  r0;
    core_req_t  r1;
    pcie_desc_t d0;
    pcie_desc_t d1;
    r0 = make_core(64'h0000_0003_0000_0000, 16'h0100, 5'd3, 200);
    r1 = make_core(64'h0000_0003_0000_8000, 16'h0300, 5'd4, 77);
    send_core(r0, 4'h6);
    expect_desc("backpressure", r0.pcie_addr, 200, 0, d0);
    send_core(r1, 4'h7);
    expect_desc("backpressure", r1.pcie_addr, 77, 1, d1);
    complete_slot(d1);
    complete_slot(d0);
    recv_packet("backpressure", 1, 77, {4'h7, 5'd4}, 16'h0300, 1'b1);
    recv_packet("backpressure", 0, 200, {4'h6, 5'd3}, 16'h0100, 1'b1);
  endtask

  task automatic test_enable();
    host_req_t  r;
    pcie_desc_t d;
    @(negedge pcie_clk);
    dma_enable = 1'b0;
    r = make_host(64'h0000_0000_cccc_0000, 4'hc, 16'h1234, 40, 32'h0000_5a5a);
    send_host(r);
    expect_desc("enable", r.pcie_addr, 40, 0, d);
    complete_slot(d);
    repeat (20) begin
      @(negedge pcie_clk);
      if (core_valid) begin
        stop_on_error("core_valid rose while dma_enable was low");
      end
    end
    dma_enable = 1'b1;
    recv_packet("enable", 0, 40, {4'hc, 5'd0}, 16'h1234, 1'b0);
    wait_status("enable", 32'h0000_5a5a);
  endtask

  initial begin
    pcie_rst         = 1'b1;
    dma_enable       = 1'b1;
    host_req         = '0;
    host_req_valid   = 1'b0;
    core_req         = '0;
    core_id          = '0;
    core_req_valid   = 1'b0;
    pcie_desc_ready  = 1'b0;
    dma_status_tag   = '0;
    dma_status_valid = 1'b0;
    dma_wr           = '0;
    dma_wr_valid     = 1'b0;
    core_ready       = 1'b0;
    repeat (4) @(posedge pcie_clk);
    @(negedge pcie_clk);
    pcie_rst = 1'b0;
    check_value("reset", "pcie_desc_valid", 0, pcie_desc_valid);
    check_value("reset", "core_valid", 0, core_valid);
    check_value("reset", "host_status_valid", 0, host_status_valid);

    test_host_read();
    test_core_read();
    test_priority();
    test_exhaustion();
    test_backpressure();
    test_enable();

    if (error_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== hw/pcie_cont_read.sv ====
`timescale 1ns/1ps
`default_nettype none

module pcie_cont_read
  import cont_read_pkg::*, core_stream_pkg::*;
(
  input  logic                  pcie_clk,
  input  logic                  pcie_rst,
  input  logic                  dma_enable,

  input  host_req_t             host_req,
  input  logic                  host_req_valid,
  output logic                  host_req_ready,
  output logic [host_tag_w-1:0] host_status_tag,
  output logic                  host_status_valid,

  input  core_req_t             core_req,
  input  logic [core_id_w-1:0]  core_id,
  input  logic                  core_req_valid,
  output logic                  core_req_ready,

  output pcie_desc_t            pcie_desc,
  output slot_t                 pcie_desc_tag,
  output logic                  pcie_desc_valid,
  input  logic                  pcie_desc_ready,

  input  slot_t                 dma_status_tag,
  input  logic                  dma_status_valid,
  input  ram_wr_t               dma_wr,
  input  logic                  dma_wr_valid,

  output core_beat_t            core_beat,
  output logic                  core_valid,
  input  logic                  core_ready
);

  pcie_desc_t             out_desc;
  logic                   out_valid;
  logic                   out_room;
  readout_desc_t          ro_in_desc;
  logic                   ro_in_valid;
  readout_desc_t          ro_desc;
  logic                   ro_valid;
  logic                   ro_ready;
  logic [word_addr_w-1:0] rd_addr;
  logic                   rd_en;
  logic [data_w-1:0]      rd_data;
  slot_t                  done_slot;
  logic                   done_valid;

  assign pcie_desc_tag = pcie_desc.tag;

  slot_tracker i_slot_tracker (
    .pcie_clk          (pcie_clk),
    .pcie_rst          (pcie_rst),
    .host_req          (host_req),
    .host_req_valid    (host_req_valid),
    .host_req_ready    (host_req_ready),
    .core_req          (core_req),
    .core_id           (core_id),
    .core_req_valid    (core_req_valid),
    .core_req_ready    (core_req_ready),
    .out_desc          (out_desc),
    .out_valid         (out_valid),
    .out_room          (out_room),
    .dma_status_tag    (dma_status_tag),
    .dma_status_valid  (dma_status_valid),
    .ro_desc           (ro_in_desc),
    .ro_valid          (ro_in_valid),
    .done_slot         (done_slot),
    .done_valid        (done_valid),
    .host_status_tag   (host_status_tag),
    .host_status_valid (host_status_valid)
  );

  desc_fifo #(.item_t(pcie_desc_t)) i_out_fifo (
    .pcie_clk  (pcie_clk),
    .pcie_rst  (pcie_rst),
    .in_item   (out_desc),
    .in_valid  (out_valid),
    .in_ready  (out_room),
    .out_item  (pcie_desc),
    .out_valid (pcie_desc_valid),
    .out_ready (pcie_desc_ready)
  );

  // At most 16 slots in flight, so this queue never fills
  desc_fifo #(.item_t(readout_desc_t)) i_ro_fifo (
    .pcie_clk  (pcie_clk),
    .pcie_rst  (pcie_rst),
    .in_item   (ro_in_desc),
    .in_valid  (ro_in_valid),
    .in_ready  (),
    .out_item  (ro_desc),
    .out_valid (ro_valid),
    .out_ready (ro_ready)
  );

  scratchpad_ram i_scratchpad_ram (
    .pcie_clk (pcie_clk),
    .wr       (dma_wr),
    .wr_valid (dma_wr_valid),
    .rd_addr  (rd_addr),
    .rd_en    (rd_en),
    .rd_data  (rd_data)
  );

  readout_engine i_readout_engine (
    .pcie_clk   (pcie_clk),
    .pcie_rst   (pcie_rst),
    .dma_enable (dma_enable),
    .desc       (ro_desc),
    .desc_valid (ro_valid),
    .desc_ready (ro_ready),
    .rd_addr    (rd_addr),
    .rd_en      (rd_en),
    .rd_data    (rd_data),
    .beat       (core_beat),
    .beat_valid (core_valid),
    .beat_ready (core_ready),
    .done_slot  (done_slot),
    .done_valid (done_valid)
  );

endmodule

`default_nettype wire

// ==== readout/readout_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module readout_engine
  import cont_read_pkg::*, core_stream_pkg::*;
(
  input  logic                   pcie_clk,
  input  logic                   pcie_rst,
  input  logic                   dma_enable,

  input  readout_desc_t          desc,
  input  logic                   desc_valid,
  output logic                   desc_ready,

  output logic [word_addr_w-1:0] rd_addr,
  output logic                   rd_en,
  input  logic [data_w-1:0]      rd_data,

  output core_beat_t             beat,
  output logic                   beat_valid,
  input  logic                   beat_ready,

  output slot_t                  done_slot,
  output logic                   done_valid
);

  typedef enum logic [1:0] {
    st_idle,
    st_header,
    st_data
  } state_t;

  state_t                 state;
  slot_t                  slot_q;
  logic [len_w-1:0]       rem_q;
  logic [dest_w-1:0]      dest_q;
  logic [core_addr_w-1:0] core_addr_q;
  logic [word_addr_w-1:0] addr_q;
  logic                   hdr_sel;
  logic [keep_w-1:0]      keep_q;
  logic                   last_q;

  logic                   can_load;
  logic                   beat_take;
  logic                   desc_take;
  logic                   rd_issue;
  logic [keep_w-1:0]      next_keep;
  logic                   next_last;
  logic [len_w-1:0]       next_rem;

  assign can_load   = !beat_valid || beat_ready;
  assign beat_take  = beat_valid && beat_ready;
  assign desc_ready = (state == st_idle) && dma_enable;
  assign desc_take  = desc_valid && desc_ready;

  // RAM output register doubles as the held data beat
  assign rd_issue = (state == st_data) && can_load && (rem_q != '0);
  assign rd_en    = rd_issue;
  assign rd_addr  = addr_q;

  always_comb begin
    if (rem_q > len_w'(word_bytes)) begin
      next_keep = '1;
      next_last = 1'b0;
      next_rem  = rem_q - len_w'(word_bytes);
    end else begin
      next_last = 1'b1;
      next_rem  = '0;
      if (rem_q[word_lsb-1:0] == '0) begin
        next_keep = '1;
      end else begin
        next_keep = (keep_w'(1) << rem_q[word_lsb-1:0]) - 1'b1;
      end
    end
  end

  always_comb begin
    beat.data = hdr_sel ? (data_w'(core_addr_q) << hdr_addr_lsb) : rd_data;
    beat.keep = keep_q;
    beat.dest = dest_q;
    beat.last = last_q;
  end

  always_ff @(posedge pcie_clk) begin
    if (desc_take) begin
      slot_q      <= desc.slot;
      rem_q       <= desc.len;
      dest_q      <= desc.dest;
      core_addr_q <= desc.core_addr;
      addr_q      <= word_addr_w'(desc.slot) << slot_word_lsb;
    end
    if ((state == st_header) && can_load) begin
      hdr_sel <= 1'b1;
      keep_q  <= hdr_keep;
      last_q  <= 1'b0;
    end
    if (rd_issue) begin
      hdr_sel <= 1'b0;
      keep_q  <= next_keep;
      last_q  <= next_last;
      rem_q   <= next_rem;
      addr_q  <= addr_q + 1'b1;
    end
    if (beat_take && last_q) begin
      done_slot <= slot_q;
    end
  end

  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      state      <= st_idle;
      beat_valid <= 1'b0;
      done_valid <= 1'b0;
    end else begin
      done_valid <= 1'b0;
      case (state)
        st_idle: begin
          if (desc_take) begin
            state <= st_header;
          end
        end
        st_header: begin
          if (can_load) begin
            beat_valid <= 1'b1;
            state      <= st_data;
          end
        end
        st_data: begin
          if (rd_issue) begin
            beat_valid <= 1'b1;
          end else if (beat_take) begin
            beat_valid <= 1'b0;
            if (last_q) begin
              done_valid <= 1'b1;
              state      <= st_idle;
            end
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== readout/scratchpad_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module scratchpad_ram
  import cont_read_pkg::*, core_stream_pkg::*;
(
  input  logic                   pcie_clk,

  input  ram_wr_t                wr,
  input  logic                   wr_valid,

  input  logic [word_addr_w-1:0] rd_addr,
  input  logic                   rd_en,
  output logic [data_w-1:0]      rd_data
);

  logic [data_w-1:0] mem [ram_words];

  // Write port owned by the DMA engine
  always_ff @(posedge pcie_clk) begin
    if (wr_valid) begin
      mem[wr.addr] <= wr.data;
    end
  end

  // Read data holds while rd_en is low
  always_ff @(posedge pcie_clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

// ==== slot_tracker/slot_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module slot_tracker
  import cont_read_pkg::*, core_stream_pkg::*;
(
  input  logic                  pcie_clk,
  input  logic                  pcie_rst,

  input  host_req_t             host_req,
  input  logic                  host_req_valid,
  output logic                  host_req_ready,

  input  core_req_t             core_req,
  input  logic [core_id_w-1:0]  core_id,
  input  logic                  core_req_valid,
  output logic                  core_req_ready,

  output pcie_desc_t            out_desc,
  output logic                  out_valid,
  input  logic                  out_room,

  input  slot_t                 dma_status_tag,
  input  logic                  dma_status_valid,

  output readout_desc_t         ro_desc,
  output logic                  ro_valid,

  input  slot_t                 done_slot,
  input  logic                  done_valid,

  output logic [host_tag_w-1:0] host_status_tag,
  output logic                  host_status_valid
);

  logic [slot_count-1:0]  free_mask;
  logic [slot_count-1:0]  alloc_mask;
  logic [slot_count-1:0]  release_mask;
  slot_t                  sel_slot;
  logic                   slot_avail;
  logic                   host_fire;
  logic                   core_fire;
  logic                   req_fire;

  logic [pcie_addr_w-1:0] req_pcie_addr;
  logic [len_w-1:0]       req_len;
  logic [dest_w-1:0]      req_dest;
  logic [core_addr_w-1:0] req_core_addr;
  logic [host_tag_w-1:0]  req_tag;

  // Per-slot bookkeeping
  logic [len_w-1:0]       len_tab       [slot_count];
  logic [dest_w-1:0]      dest_tab      [slot_count];
  logic [core_addr_w-1:0] core_addr_tab [slot_count];
  logic [host_tag_w-1:0]  host_tag_tab  [slot_count];

  // Lowest free slot wins
  always_comb begin
    sel_slot = '0;
    for (int i = slot_count - 1; i >= 0; i--) begin
      if (free_mask[i]) begin
        sel_slot = slot_t'(i);
      end
    end
  end

  assign slot_avail     = |free_mask;
  assign host_req_ready = slot_avail && out_room;
  assign core_req_ready = slot_avail && out_room && !host_req_valid;
  assign host_fire      = host_req_valid && host_req_ready;
  assign core_fire      = core_req_valid && core_req_ready;
  assign req_fire       = host_fire || core_fire;

  assign alloc_mask   = req_fire ? (slot_count'(1) << sel_slot) : '0;
  assign release_mask = done_valid ? (slot_count'(1) << done_slot) : '0;

  always_comb begin
    if (host_fire) begin
      req_pcie_addr = host_req.pcie_addr;
      req_len       = host_req.len;
      req_dest      = {host_req.ram_addr[core_addr_w +: core_id_w], dest_low_w'(0)};
      req_core_addr = host_req.ram_addr[core_addr_w-1:0];
      req_tag       = host_req.tag;
    end else begin
      req_pcie_addr = core_req.pcie_addr;
      req_len       = core_req.len;
      req_dest      = {core_id, core_req.dest_low};
      req_core_addr = core_req.core_addr;
      req_tag       = '0;
    end
  end

  always_ff @(posedge pcie_clk) begin
    if (req_fire) begin
      len_tab[sel_slot]       <= req_len;
      dest_tab[sel_slot]      <= req_dest;
      core_addr_tab[sel_slot] <= req_core_addr;
      host_tag_tab[sel_slot]  <= req_tag;

      out_desc.pcie_addr <= req_pcie_addr;
      out_desc.ram_addr  <= ram_addr_w'(sel_slot) << slot_lsb;
      out_desc.len       <= req_len;
      out_desc.tag       <= sel_slot;
    end

    // Readout is queued once the DMA engine has filled the slot
    if (dma_status_valid) begin
      ro_desc.slot      <= dma_status_tag;
      ro_desc.len       <= len_tab[dma_status_tag];
      ro_desc.dest      <= dest_tab[dma_status_tag];
      ro_desc.core_addr <= core_addr_tab[dma_status_tag];
    end

    if (done_valid) begin
      host_status_tag <= host_tag_tab[done_slot];
    end
  end

  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      free_mask         <= '1;
      out_valid         <= 1'b0;
      ro_valid          <= 1'b0;
      host_status_valid <= 1'b0;
    end else begin
      free_mask         <= (free_mask & ~alloc_mask) | release_mask;
      out_valid         <= req_fire;
      ro_valid          <= dma_status_valid;
      // Core requests carry tag 0 and get no status
      host_status_valid <= done_valid && (host_tag_tab[done_slot] != '0);
    end
  end

endmodule

`default_nettype wire

// ==== hw/desc_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module desc_fifo
  import cont_read_pkg::*;
#(
  parameter type item_t = logic [7:0]
) (
  input  logic  pcie_clk,
  input  logic  pcie_rst,

  input  item_t in_item,
  input  logic  in_valid,
  output logic  in_ready,

  output item_t out_item,
  output logic  out_valid,
  input  logic  out_ready
);

  item_t                 mem [fifo_depth];
  logic [fifo_ptr_w-1:0] wr_ptr;
  logic [fifo_ptr_w-1:0] rd_ptr;
  logic [fifo_ptr_w:0]   count;
  logic                  push;
  logic                  pop;

  assign in_ready  = (count != (fifo_ptr_w + 1)'(fifo_depth));
  assign out_valid = (count != '0);
  assign out_item  = mem[rd_ptr];

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  always_ff @(posedge pcie_clk) begin
    if (push) begin
      mem[wr_ptr] <= in_item;
    end
  end

  // Pointers wrap on their own since depth is a power of two
  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== common/cont_read_pkg.sv ====
`default_nettype none

package cont_read_pkg;

  localparam int slot_count  = 16;
  localparam int slot_w      = $clog2(slot_count);
  localparam int slot_bytes  = 2048;
  localparam int word_bytes  = 16;
  localparam int ram_words   = 2048;
  localparam int ram_addr_w  = 15;
  localparam int word_addr_w = 11;
  localparam int pcie_addr_w = core_stream_pkg::req_addr_w;
  localparam int len_w       = core_stream_pkg::req_len_w;
  localparam int host_tag_w  = 32;
  localparam int fifo_depth  = 16;
  localparam int fifo_ptr_w  = $clog2(fifo_depth);

  // Slot number position in byte and word addresses
  localparam int word_lsb      = $clog2(word_bytes);
  localparam int slot_lsb      = $clog2(slot_bytes);
  localparam int slot_word_lsb = slot_lsb - word_lsb;

  // Host ram_addr holds core id above the core address
  localparam int host_addr_w = core_stream_pkg::core_id_w + core_stream_pkg::core_addr_w;

  typedef logic [slot_w-1:0] slot_t;

  typedef struct packed {
    logic [pcie_addr_w-1:0] pcie_addr;
    logic [ram_addr_w-1:0]  ram_addr;
    logic [len_w-1:0]       len;
    slot_t                  tag;
  } pcie_desc_t;

  typedef struct packed {
    logic [pcie_addr_w-1:0] pcie_addr;
    logic [host_addr_w-1:0] ram_addr;
    logic [len_w-1:0]       len;
    logic [host_tag_w-1:0]  tag;
  } host_req_t;

  typedef struct packed {
    logic [word_addr_w-1:0]             addr;
    logic [core_stream_pkg::data_w-1:0] data;
  } ram_wr_t;

  typedef struct packed {
    slot_t                                   slot;
    logic [len_w-1:0]                        len;
    logic [core_stream_pkg::dest_w-1:0]      dest;
    logic [core_stream_pkg::core_addr_w-1:0] core_addr;
  } readout_desc_t;

endpackage

`default_nettype wire

// ==== common/core_stream_pkg.sv ====
`default_nettype none

package core_stream_pkg;

  localparam int core_id_w    = 4;
  localparam int core_addr_w  = 16;
  localparam int dest_w       = 9;
  localparam int dest_low_w   = dest_w - core_id_w;
  localparam int data_w       = 128;
  localparam int keep_w       = 16;
  localparam int hdr_addr_lsb = 32;

  // Request address and length as seen by the cores
  localparam int req_addr_w = 64;
  localparam int req_len_w  = 16;

  // Header beat covers the low 8 bytes
  localparam logic [keep_w-1:0] hdr_keep = 16'h00ff;

  typedef struct packed {
    logic [req_addr_w-1:0]  pcie_addr;
    logic [core_addr_w-1:0] core_addr;
    logic [dest_low_w-1:0]  dest_low;
    logic [req_len_w-1:0]   len;
  } core_req_t;

  typedef struct packed {
    logic [data_w-1:0] data;
    logic [keep_w-1:0] keep;
    logic [dest_w-1:0] dest;
    logic              last;
  } core_beat_t;

endpackage

`default_nettype wire
